// ==== rtl/shim_pkg.sv ====
// Shim widths, byte counts, configuration struct and sequencer phase enum
`default_nettype none

package shim_pkg;

    // ------------------------------------------------------------------------
    // Data path geometry
    // ------------------------------------------------------------------------

    // Width of one data beat on both streams and the write channel
    localparam int data_bits  = 64;

    // Bytes carried by one beat
    localparam int beat_bytes = data_bits / 8;

    // Shift that turns a byte count into a beat count
    localparam int beat_shift = $clog2(beat_bytes);

    // One metadata record spans two beats
    localparam int md_beats   = 2;
    localparam int md_bytes   = md_beats * beat_bytes;

    // Byte address on the bus, also used for ring offsets
    typedef logic [63:0] addr_t;

    // ------------------------------------------------------------------------
    // Static configuration, held while resetn is high
    // ------------------------------------------------------------------------
    typedef struct packed {
        // Bytes per outgoing packet
        logic [15:0] packet_size;
        // Bytes per full frame, both halves
        logic [31:0] frame_size;
        // Frame-data ring base and length
        addr_t       fd_ring_addr;
        addr_t       fd_ring_size;
        // Metadata ring base and length
        addr_t       md_ring_addr;
        addr_t       md_ring_size;
        // Where the frame counter lands
        addr_t       fc_addr;
    } shim_cfg_t;

    // Sequencer phases, in the order they run for each half-frame
    typedef enum logic [1:0] {
        phase_fd,
        phase_md1,
        phase_md2,
        phase_fc
    } phase_t;

endpackage

`default_nettype wire

// ==== rtl/axi_wr_pkg.sv ====
// Write-address and write-data channel structs and the data-beat type
`default_nettype none

package axi_wr_pkg;

    // ------------------------------------------------------------------------
    // Payload types
    // ------------------------------------------------------------------------

    // One data beat
    typedef logic [shim_pkg::data_bits-1:0]  beat_t;

    // One strobe bit per byte lane
    typedef logic [shim_pkg::beat_bytes-1:0] strb_t;

    // ------------------------------------------------------------------------
    // Write channels
    // ------------------------------------------------------------------------

    // Address channel, len is beats minus one
    typedef struct packed {
        shim_pkg::addr_t addr;
        logic [7:0]      len;
    } aw_t;

    // Data channel
    typedef struct packed {
        beat_t data;
        strb_t strb;
        logic  last;
    } w_t;

endpackage

`default_nettype wire

// ==== rtl/frame_tracker.sv ====
// Packets-per-half-frame decode, packet counter and frame-data ring pointer
`default_nettype none

module frame_tracker (
    input  logic                clk,
    input  logic                resetn,
    input  shim_pkg::shim_cfg_t cfg,
    // Last beat of a frame-data packet just moved
    input  logic                packet_done,
    output shim_pkg::addr_t     fd_offset,
    output logic [7:0]          burst_len,
    output logic                last_packet
);
    import shim_pkg::*;

    // ------------------------------------------------------------------------
    // Packets per frame
    // ------------------------------------------------------------------------

    // Shift amount for the supported packet sizes
    logic [4:0]  size_shift;
    logic        size_ok;
    logic [31:0] packets_per_frame;
    logic [31:0] packets_half;
    logic [31:0] packets_target;

    always_comb begin
        size_ok    = 1'b1;
        size_shift = 5'd0;
        case (cfg.packet_size)
            16'd64:   size_shift = 5'd6;
            16'd128:  size_shift = 5'd7;
            16'd256:  size_shift = 5'd8;
            16'd512:  size_shift = 5'd9;
            16'd1024: size_shift = 5'd10;
            16'd2048: size_shift = 5'd11;
            16'd4096: size_shift = 5'd12;
            16'd8192: size_shift = 5'd13;
            default:  size_ok    = 1'b0;
        endcase
    end

    // Power-of-two sizes divide by shifting, anything else is one packet
    assign packets_per_frame = size_ok ? (cfg.frame_size >> size_shift) : 32'd1;

    // The other half of the frame goes through a sibling instance
    assign packets_half   = packets_per_frame >> 1;
    // A half of zero still carries one packet
    assign packets_target = (packets_half == 32'd0) ? 32'd1 : packets_half;

    // ------------------------------------------------------------------------
    // Packet counter, counting from one
    // ------------------------------------------------------------------------
    logic [31:0] packet_count;

    assign last_packet = (packet_count == packets_target);

    // ------------------------------------------------------------------------
    // Frame-data ring pointer
    // ------------------------------------------------------------------------
    addr_t next_fd_offset;

    assign next_fd_offset = fd_offset + addr_t'(cfg.packet_size);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            packet_count <= 32'd1;
            fd_offset    <= '0;
        end else if (packet_done) begin
            // Restart the count after the half-frame is complete
            packet_count <= last_packet ? 32'd1 : packet_count + 32'd1;
            // Wrap to the ring start when the next packet would not fit
            fd_offset    <= (next_fd_offset < cfg.fd_ring_size) ? next_fd_offset : '0;
        end
    end

    // Burst length in beats minus one
    logic [15:0] packet_beats;

    assign packet_beats = cfg.packet_size >> beat_shift;
    assign burst_len    = packet_beats[7:0] - 8'd1;

endmodule

`default_nettype wire

// ==== rtl/metadata_buffer.sv ====
// Two-beat metadata capture and metadata ring pointer
`default_nettype none

module metadata_buffer (
    input  logic              clk,
    input  logic              resetn,
    // Metadata stream
    input  axi_wr_pkg::beat_t md_data,
    input  logic              md_valid,
    output logic              md_ready,
    // Second metadata beat has left on the write channel
    input  logic              md_done,
    input  shim_pkg::addr_t   md_ring_size,
    // Both beats held and ready to be written
    output logic              md_full,
    output axi_wr_pkg::beat_t md_beat0,
    output axi_wr_pkg::beat_t md_beat1,
    output shim_pkg::addr_t   md_offset
);
    import shim_pkg::*;

    // ------------------------------------------------------------------------
    // Capture FSM
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        fill_empty,
        fill_half,
        fill_held
    } fill_t;

    fill_t fill_state;
    logic  md_take;

    // Accept beats until both are held
    assign md_ready = (fill_state != fill_held);
    assign md_full  = (fill_state == fill_held);
    assign md_take  = md_valid & md_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fill_state <= fill_empty;
        end else begin
            case (fill_state)
                fill_empty: if (md_take) fill_state <= fill_half;
                fill_half:  if (md_take) fill_state <= fill_held;
                // Free the record once it has gone out
                fill_held:  if (md_done) fill_state <= fill_empty;
                default:    fill_state <= fill_empty;
            endcase
        end
    end

    // Beat registers, loaded in arrival order
    always_ff @(posedge clk) begin
        if (md_take && fill_state == fill_empty) md_beat0 <= md_data;
        if (md_take && fill_state == fill_half)  md_beat1 <= md_data;
    end

    // ------------------------------------------------------------------------
    // Metadata ring pointer
    // ------------------------------------------------------------------------
    addr_t next_md_offset;

    assign next_md_offset = md_offset + addr_t'(md_bytes);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            md_offset <= '0;
        end else if (md_done) begin
            md_offset <= (next_md_offset < md_ring_size) ? next_md_offset : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/write_sequencer.sv ====
// Phase FSM, frame counter and the write-channel multiplexer
`default_nettype none

module write_sequencer (
    input  logic                clk,
    input  logic                resetn,
    input  shim_pkg::shim_cfg_t cfg,
    // Frame stream
    input  axi_wr_pkg::beat_t   fd_data,
    input  logic                fd_valid,
    input  logic                fd_last,
    output logic                fd_ready,
    // From the frame tracker
    input  shim_pkg::addr_t     fd_offset,
    input  logic [7:0]          burst_len,
    input  logic                last_packet,
    // From the metadata buffer
    input  logic                md_full,
    input  axi_wr_pkg::beat_t   md_beat0,
    input  axi_wr_pkg::beat_t   md_beat1,
    input  shim_pkg::addr_t     md_offset,
    // Write channels
    output axi_wr_pkg::w_t      w,
    output logic                w_valid,
    input  logic                w_ready,
    output axi_wr_pkg::aw_t     aw,
    output logic                aw_valid,
    // Strobes back to the tracker and the buffer
    output logic                packet_done,
    output logic                md_done,
    output logic [31:0]         frame_count
);
    import shim_pkg::*;
    import axi_wr_pkg::*;

    phase_t phase;
    // Next frame-data beat opens a new burst
    logic   fd_first;
    logic   w_move;
    logic   burst_first;
    logic [31:0] fc_value;

    assign w_move   = w_valid & w_ready;
    assign fc_value = frame_count + 32'd1;

    // ------------------------------------------------------------------------
    // Write-data channel
    // ------------------------------------------------------------------------
    always_comb begin
        w.strb = '1;
        case (phase)
            phase_fd: begin
                w.data  = fd_data;
                w.last  = fd_last;
                w_valid = fd_valid;
            end
            phase_md1: begin
                w.data  = md_beat0;
                w.last  = 1'b0;
                // Hold off until the whole record is captured
                w_valid = md_full;
            end
            phase_md2: begin
                w.data  = md_beat1;
                w.last  = 1'b1;
                w_valid = md_full;
            end
            default: begin
                // Frame counter in the low four bytes
                w.data  = beat_t'(fc_value);
                w.strb  = strb_t'(8'h0f);
                w.last  = 1'b1;
                w_valid = 1'b1;
            end
        endcase
    end

    // Stream moves straight through while carrying frame data
    assign fd_ready = (phase == phase_fd) & w_ready;

    // ------------------------------------------------------------------------
    // Write-address channel
    // ------------------------------------------------------------------------
    always_comb begin
        case (phase)
            phase_fd: begin
                aw.addr = cfg.fd_ring_addr + fd_offset;
                aw.len  = burst_len;
            end
            phase_md1, phase_md2: begin
                aw.addr = cfg.md_ring_addr + md_offset;
                aw.len  = 8'd1;
            end
            default: begin
                aw.addr = cfg.fc_addr;
                aw.len  = 8'd0;
            end
        endcase
    end

    // Address goes out with the first beat of each burst, md2 continues md1
    assign burst_first = (phase == phase_fd) ? fd_first : (phase != phase_md2);
    assign aw_valid    = w_move & burst_first;

    assign packet_done = (phase == phase_fd) & w_move & fd_last;
    assign md_done     = (phase == phase_md2) & w_move;

    // ------------------------------------------------------------------------
    // Phase FSM and frame counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase       <= phase_fd;
            fd_first    <= 1'b1;
            frame_count <= 32'd0;
        end else begin
            case (phase)
                phase_fd: begin
                    if (w_move) fd_first <= fd_last;
                    if (packet_done && last_packet) phase <= phase_md1;
                end
                phase_md1: if (w_move) phase <= phase_md2;
                phase_md2: if (w_move) phase <= phase_fc;
                default: begin
                    if (w_move) begin
                        frame_count <= fc_value;
                        phase       <= phase_fd;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rdmx_shim.sv ====
// Top level of the write shim, joining tracker, metadata buffer and sequencer
`default_nettype none

module rdmx_shim (
    input  logic                clk,
    input  logic                resetn,
    input  shim_pkg::shim_cfg_t cfg,
    // Frame stream
    input  axi_wr_pkg::beat_t   fd_data,
    input  logic                fd_valid,
    input  logic                fd_last,
    output logic                fd_ready,
    // Metadata stream
    input  axi_wr_pkg::beat_t   md_data,
    input  logic                md_valid,
    output logic                md_ready,
    // Write channels
    output axi_wr_pkg::w_t      w,
    output logic                w_valid,
    input  logic                w_ready,
    output axi_wr_pkg::aw_t     aw,
    output logic                aw_valid,
    output logic [31:0]         frame_count
);
    import shim_pkg::*;
    import axi_wr_pkg::*;

    // ------------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------------
    addr_t      fd_offset;
    logic [7:0] burst_len;
    logic       last_packet;
    logic       packet_done;
    logic       md_full;
    beat_t      md_beat0;
    beat_t      md_beat1;
    addr_t      md_offset;
    logic       md_done;

    // Packet counting and frame-data ring
    frame_tracker u_frame_tracker (
        .clk, .resetn, .cfg, .packet_done,
        .fd_offset, .burst_len, .last_packet
    );

    // Metadata record and metadata ring
    metadata_buffer u_metadata_buffer (
        .clk, .resetn, .md_data, .md_valid, .md_ready, .md_done,
        .md_ring_size(cfg.md_ring_size),
        .md_full, .md_beat0, .md_beat1, .md_offset
    );

    // Drives the bus from whichever source the phase selects
    write_sequencer u_write_sequencer (
        .clk, .resetn, .cfg,
        .fd_data, .fd_valid, .fd_last, .fd_ready,
        .fd_offset, .burst_len, .last_packet,
        .md_full, .md_beat0, .md_beat1, .md_offset,
        .w, .w_valid, .w_ready, .aw, .aw_valid,
        .packet_done, .md_done, .frame_count
    );

endmodule

`default_nettype wire

// ==== tests/tb_rdmx_shim.sv ====
// Table-driven testbench for the write shim with stream drivers, bus slave, checker, watchdog
`default_nettype none

module tb_rdmx_shim;
    timeunit 1ns;
    timeprecision 100ps;

    import shim_pkg::*;
    import axi_wr_pkg::*;

    localparam int half_period = 4;
    localparam int n_rows      = 4;

    // Ring bases and frame-counter address, shared by every row
    localparam addr_t fd_base = 64'h0000_0100_0000_0000;
    localparam addr_t md_base = 64'h0000_0000_0002_0000;
    localparam addr_t fc_base = 64'h0000_0000_0003_0008;

    // ------------------------------------------------------------------------
    // Test table
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0] packet_size;
        logic [31:0] frame_size;
        addr_t       fd_ring_size;
        addr_t       md_ring_size;
        // Half-frames to run, one frame-counter write each
        int          frames;
        // Packets per half-frame the decode must give
        int          pph;
        // Random stalls on w_ready and both streams
        logic        bp;
    } row_t;

    row_t rows [n_rows] = '{
        // 200-byte ring wraps after four 64-byte packets, not on a frame boundary
        '{16'd64,  32'd512,  64'd200, 64'd48, 3, 4, 1'b0},
        '{16'd64,  32'd512,  64'd200, 64'd48, 3, 4, 1'b1},
        // 96 bytes is no power of two, so metadata after every packet
        '{16'd96,  32'd4096, 64'd400, 64'd64, 6, 1, 1'b1},
        '{16'd128, 32'd256,  64'd512, 64'd32, 3, 1, 1'b0}
    };

    typedef enum logic [1:0] {kind_fd, kind_md, kind_fc} kind_t;

    // One expected beat on w, with the address that must come with it
    typedef struct packed {
        kind_t       kind;
        logic        has_aw;
        addr_t       addr;
        logic [7:0]  len;
        beat_t       data;
        strb_t       strb;
        logic        last;
        // Half-frame this beat belongs to
        int          rec;
    } exp_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } fd_beat_t;

    // Metadata beat, offered once the frame stream is down to fd_left beats
    typedef struct packed {
        beat_t data;
        int    fd_left;
    } md_beat_t;

    // DUT ports
    logic        clk;
    logic        resetn;
    shim_cfg_t   cfg;
    beat_t       fd_data;
    logic        fd_valid;
    logic        fd_last;
    logic        fd_ready;
    beat_t       md_data;
    logic        md_valid;
    logic        md_ready;
    w_t          w;
    logic        w_valid;
    logic        w_ready;
    aw_t         aw;
    logic        aw_valid;
    logic [31:0] frame_count;

    // Testbench state
    exp_t        exp_q[$];
    fd_beat_t    fd_stim_q[$];
    md_beat_t    md_stim_q[$];
    exp_t        seen;
    logic        running;
    logic        bp_on;
    logic        fd_fire;
    logic        md_fire;
    int          md_accepted;
    // Metadata beats released after their record went out
    int          md_freed;
    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    rdmx_shim uut (
        .clk, .resetn, .cfg,
        .fd_data, .fd_valid, .fd_last, .fd_ready,
        .md_data, .md_valid, .md_ready,
        .w, .w_valid, .w_ready, .aw, .aw_valid, .frame_count
    );

    always #half_period clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    // High three times in four under stalls, always high otherwise
    function automatic logic go_bit(input logic stall);
        if (!stall) begin
            return 1'b1;
        end
        return lfsr_step() | lfsr_step();
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    function automatic shim_cfg_t make_cfg(input row_t cur);
        shim_cfg_t c;
        c.packet_size  = cur.packet_size;
        c.frame_size   = cur.frame_size;
        c.fd_ring_addr = fd_base;
        c.fd_ring_size = cur.fd_ring_size;
        c.md_ring_addr = md_base;
        c.md_ring_size = cur.md_ring_size;
        c.fc_addr      = fc_base;
        return c;
    endfunction

    // Stream stimulus and the write sequence it must produce
    task automatic build_expected(input row_t cur);
        addr_t       fd_off;
        addr_t       md_off;
        addr_t       next_off;
        logic [31:0] fc;
        int          beats;
        int          fd_total;
        exp_t        e;
        fd_beat_t    fb;
        md_beat_t    mb;
        fd_off   = '0;
        md_off   = '0;
        fc       = '0;
        beats    = int'(cur.packet_size) / beat_bytes;
        fd_total = cur.frames * cur.pph * beats;
        exp_q.delete();
        fd_stim_q.delete();
        md_stim_q.delete();
        for (int f = 0; f < cur.frames; f++) begin
            for (int p = 0; p < cur.pph; p++) begin
                for (int b = 0; b < beats; b++) begin
                    fb.data = lfsr_bits(data_bits);
                    fb.last = (b == beats - 1);
                    fd_stim_q.push_back(fb);
                    e = '{kind_fd, (b == 0), fd_base + fd_off, 8'(beats - 1),
                          fb.data, strb_t'('1), fb.last, f};
                    exp_q.push_back(e);
                end
                next_off = fd_off + addr_t'(cur.packet_size);
                fd_off   = (next_off < cur.fd_ring_size) ? next_off : '0;
            end
            // Record arrives only after this half-frame's last beat is offered
            mb.fd_left = fd_total - (f + 1) * cur.pph * beats;
            // Two metadata beats as one burst, address only with the first
            e = '{kind_md, 1'b1, md_base + md_off, 8'd1, lfsr_bits(data_bits),
                  strb_t'('1), 1'b0, f};
            mb.data = e.data;
            md_stim_q.push_back(mb);
            exp_q.push_back(e);
            e = '{kind_md, 1'b0, md_base + md_off, 8'd1, lfsr_bits(data_bits),
                  strb_t'('1), 1'b1, f};
            mb.data = e.data;
            md_stim_q.push_back(mb);
            exp_q.push_back(e);
            next_off = md_off + addr_t'(md_bytes);
            md_off   = (next_off < cur.md_ring_size) ? next_off : '0;
            fc       = fc + 32'd1;
            e = '{kind_fc, 1'b1, fc_base, 8'd0, beat_t'(fc), strb_t'(8'h0f), 1'b1, f};
            exp_q.push_back(e);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stream drivers and bus slave
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (running) begin
            // A beat on offer stays until it is taken
            if (!fd_valid || fd_fire) begin
                if (fd_stim_q.size() != 0 && go_bit(bp_on)) begin
                    fd_data  <= fd_stim_q[0].data;
                    fd_last  <= fd_stim_q[0].last;
                    fd_valid <= 1'b1;
                    void'(fd_stim_q.pop_front());
                end else begin
                    fd_valid <= 1'b0;
                end
            end
            // Late metadata, so the sequencer has to wait for a full record
            if (!md_valid || md_fire) begin
                if (md_stim_q.size() != 0 && fd_stim_q.size() <= md_stim_q[0].fd_left &&
                        go_bit(bp_on)) begin
                    md_data  <= md_stim_q[0].data;
                    md_valid <= 1'b1;
                    void'(md_stim_q.pop_front());
                end else begin
                    md_valid <= 1'b0;
                end
            end
            w_ready <= go_bit(bp_on);
        end else begin
            fd_valid <= 1'b0;
            md_valid <= 1'b0;
            w_ready  <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Monitor, sampled mid-cycle for the handshake at the next edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (resetn) begin
            // Frame stream follows the slave only while frame data is due
            check("fd_ready", 64'(fd_ready),
                  64'(w_ready && (exp_q.size() == 0 || exp_q[0].kind == kind_fd)));
            // Metadata stream stalls only while a whole record is held
            check("md_ready", 64'(md_ready), 64'((md_accepted - md_freed) < md_beats));
        end
        if (resetn && w_valid && w_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected write of %h at %0d ns after the last expected one",
                         w.data, $time);
            end else begin
                seen = exp_q.pop_front();
                check("w.data", w.data, seen.data);
                check("w.strb", 64'(w.strb), 64'(seen.strb));
                check("w.last", 64'(w.last), 64'(seen.last));
                check("aw_valid", 64'(aw_valid), 64'(seen.has_aw));
                if (seen.has_aw) begin
                    check("aw.addr", aw.addr, seen.addr);
                    check("aw.len", 64'(aw.len), 64'(seen.len));
                end
                // Both beats of this record must already be inside the DUT
                if (seen.kind == kind_md && md_accepted < 2 * (seen.rec + 1)) begin
                    errors++;
                    $display("Metadata record %0d written at %0d ns before both beats were accepted",
                             seen.rec, $time);
                end
                if (seen.kind == kind_md && seen.last) begin
                    md_freed += md_beats;
                end
                if (seen.kind == kind_fc) begin
                    check("frame_count", 64'(frame_count), seen.data - 64'd1);
                end
            end
        end else if (resetn) begin
            check("aw_valid", 64'(aw_valid), 64'd0);
        end
        if (resetn && md_valid && md_ready) begin
            md_accepted++;
        end
        fd_fire = fd_valid && fd_ready;
        md_fire = md_valid && md_ready;
    end

    // ------------------------------------------------------------------------
    // Row sequencing
    // ------------------------------------------------------------------------
    initial begin : main_seq
        row_t cur;
        clk         = 1'b0;
        resetn      = 1'b0;
        cfg         = '0;
        fd_data     = '0;
        fd_valid    = 1'b0;
        fd_last     = 1'b0;
        md_data     = '0;
        md_valid    = 1'b0;
        w_ready     = 1'b0;
        running     = 1'b0;
        bp_on       = 1'b0;
        fd_fire     = 1'b0;
        md_fire     = 1'b0;
        md_accepted = 0;
        md_freed    = 0;
        errors      = 0;
        checks      = 0;
        lfsr_state  = 32'hafac;
        for (int r = 0; r < n_rows; r++) begin
            cur = rows[r];
            @(posedge clk);
            resetn      <= 1'b0;
            bp_on       <= cur.bp;
            cfg         <= make_cfg(cur);
            md_accepted = 0;
            md_freed    = 0;
            build_expected(cur);
            $display("Row %0d: %0d-byte packets, %0d per half-frame, %0d half-frames, stalls %0d",
                     r, cur.packet_size, cur.pph, cur.frames, cur.bp);
            repeat (5) @(posedge clk);
            resetn  <= 1'b1;
            running <= 1'b1;
            while (exp_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            @(negedge clk);
            check("frame_count", 64'(frame_count), 64'(cur.frames));
            if (fd_stim_q.size() != 0 || md_stim_q.size() != 0) begin
                errors++;
                $display("Row %0d ended with stream beats that were never accepted", r);
            end
            @(posedge clk);
            running <= 1'b0;
        end
        @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Limit from the total beats in the table, stalls roughly halve throughput
    initial begin : watchdog
        int total_beats;
        int limit_ns;
        total_beats = 0;
        for (int r = 0; r < n_rows; r++) begin
            total_beats += rows[r].frames *
                (rows[r].pph * (int'(rows[r].packet_size) / beat_bytes) + 3);
        end
        limit_ns = (4 * total_beats + 20 * n_rows + 100) * 2 * half_period;
        #(limit_ns);
        $display("Timeout after %0d ns, the expected writes were not all seen", limit_ns);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/shim_pkg.sv
rtl/axi_wr_pkg.sv
rtl/frame_tracker.sv
rtl/metadata_buffer.sv
rtl/write_sequencer.sv
rtl/rdmx_shim.sv
tests/tb_rdmx_shim.sv

// ==== Makefile ====
# Verilator flow for the write shim testbench

VERILATOR ?= verilator
TOP       ?= tb_rdmx_shim
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --timescale $(TIMESCALE)
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
